/* files.f */
verilog/side_ch_pkg.sv
verilog/side_ch_cfg_if.sv
verilog/side_ch_fifo_if.sv
verilog/side_ch_regs.sv
verilog/side_ch_control.sv
verilog/side_ch_event_counter.sv
verilog/side_ch_fifo.sv
verilog/side_ch_m_axis.sv
verilog/side_ch.sv
verification/side_ch_properties.sv
verification/tb_side_ch.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the side channel testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_side_ch -f files.f -o sim_side_ch

./obj_dir/sim_side_ch | tee sim.log

if grep -q "=== FAIL ===" sim.log
then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* verification/side_ch_properties.sv */
// output stream protocol checks

`timescale 1ns/1ps

module side_ch_properties
  import side_ch_pkg::*;
(
  input logic                  clk,
  input logic                  rst_n,
  input logic                  soft_reset,
  input logic                  m_axis_tvalid,
  input logic [AXIS_WIDTH-1:0] m_axis_tdata,
  input logic                  m_axis_tlast,
  input logic                  m_axis_tready
);

  // a stalled word holds until it is taken
  property hold_under_backpressure;
    @(posedge clk) disable iff (!rst_n || soft_reset)
      (m_axis_tvalid && !m_axis_tready) |=>
        (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast));
  endproperty

  property idle_after_reset;
    @(posedge clk) $rose(rst_n) |-> (!m_axis_tvalid && !m_axis_tlast);
  endproperty

  // tlast only marks a word on the bus
  property last_with_valid;
    @(posedge clk) disable iff (!rst_n || soft_reset)
      m_axis_tlast |-> m_axis_tvalid;
  endproperty

  stall_hold: assert property (hold_under_backpressure)
    else $error("stream word changed while stalled");

  reset_idle: assert property (idle_after_reset)
    else $error("stream not idle after reset");

  last_valid: assert property (last_with_valid)
    else $error("tlast without tvalid");

endmodule

bind side_ch side_ch_properties props_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .soft_reset    (cfg_bus.soft_reset),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tlast  (m_axis_tlast),
  .m_axis_tready (m_axis_tready)
);

/* verification/tb_side_ch.sv */
// side channel testbench

`timescale 1ns/1ps

module tb_side_ch
  import side_ch_pkg::*;
();

  localparam int FIFO_DEPTH    = 256;
  localparam int COUNTER_WIDTH = 16;
  // the tests need a few thousand cycles
  localparam int MAX_CYCLES    = 20000;

  logic                      clk;
  logic                      rst_n;
  logic                      reg_wr_en;
  logic [REG_ADDR_WIDTH-1:0] reg_addr;
  logic [REG_WIDTH-1:0]      reg_wdata;
  logic [REG_WIDTH-1:0]      reg_rdata;
  logic [TSF_WIDTH-1:0]      tsf_runtime_val;
  logic                      long_preamble_detected;
  logic                      short_preamble_detected;
  logic [CSI_WIDTH-1:0]      csi;
  logic                      csi_valid;
  logic                      pkt_header_valid;
  logic                      pkt_header_valid_strobe;
  logic                      fcs_in_strobe;
  logic                      fcs_ok;
  logic                      m_axis_tvalid;
  logic [AXIS_WIDTH-1:0]     m_axis_tdata;
  logic                      m_axis_tlast;
  logic                      m_axis_tready;

  // words written to the buffer and not yet streamed
  logic [AXIS_WIDTH-1:0] expected [$];
  logic [AXIS_WIDTH-1:0] exp_word;
  int error_count;
  int cycle_count;
  int beat_cnt;
  int dma_len_model;
  int drops;
  int captured;
  bit capture_on;
  bit hold_ready;
  logic [REG_WIDTH-1:0] fill;

  side_ch #(
    .FIFO_DEPTH    (FIFO_DEPTH),
    .COUNTER_WIDTH (COUNTER_WIDTH)
  ) dut (.*);

  always #4 clk = ~clk;

  // random gaps in tready unless the stream is stalled on purpose
  always @(posedge clk)
  begin
    #1;
    if (hold_ready)
      m_axis_tready = 1'b0;
    else
      m_axis_tready = ($urandom_range(3) != 0);
  end

  // stream checker, sampled mid-cycle
  always @(negedge clk)
  begin
    if (rst_n && m_axis_tvalid)
    begin
      assert (expected.size() != 0)
      else
      begin
        error_count++;
        $display("[ERROR] %0t: stream valid with no word expected", $time);
      end
      if (m_axis_tready && expected.size() != 0)
      begin
        exp_word = expected.pop_front();
        assert (m_axis_tdata == exp_word)
        else
        begin
          error_count++;
          $display("[ERROR] %0t: tdata 0x%h, expected 0x%h", $time, m_axis_tdata, exp_word);
        end
        assert (m_axis_tlast == (beat_cnt == dma_len_model - 1))
        else
        begin
          error_count++;
          $display("[ERROR] %0t: tlast %0b on word %0d of %0d", $time, m_axis_tlast,
                   beat_cnt + 1, dma_len_model);
        end
        beat_cnt = (beat_cnt == dma_len_model - 1) ? 0 : beat_cnt + 1;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: %0d", error_count);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input logic [REG_ADDR_WIDTH-1:0] addr,
                           input logic [REG_WIDTH-1:0] data);
    step();
    reg_wr_en = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    step();
    reg_wr_en = 1'b0;
  endtask

  task automatic read_reg(input logic [REG_ADDR_WIDTH-1:0] addr,
                          output logic [REG_WIDTH-1:0] data);
    step();
    reg_addr = addr;
    @(negedge clk);
    data = reg_rdata;
  endtask

  task automatic check_reg(input logic [REG_ADDR_WIDTH-1:0] addr,
                           input logic [REG_WIDTH-1:0] exp, input string what);
    logic [REG_WIDTH-1:0] got;
    read_reg(addr, got);
    assert (got == exp)
    else
    begin
      error_count++;
      $display("[ERROR] %0t: %s read 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic set_dma_len(input int len);
    write_reg(REG_DMA_LEN, REG_WIDTH'(len));
    dma_len_model = len;
    beat_cnt      = 0;
  endtask

  task automatic set_capture(input bit on);
    write_reg(REG_CAPTURE, REG_WIDTH'(on));
    capture_on = on;
  endtask

  // preamble with a time stamp, then 64 back-to-back csi samples
  task automatic send_frame();
    logic [TSF_WIDTH-1:0] tsf;
    logic [CSI_WIDTH-1:0] sample;
    logic [CSI_WIDTH-1:0] low_sample;
    bit take;
    tsf  = {$urandom, $urandom};
    take = capture_on && (expected.size() <= FIFO_DEPTH - FRAME_WORDS);
    step();
    tsf_runtime_val        = tsf;
    long_preamble_detected = 1'b1;
    if (take)
    begin
      expected.push_back(tsf);
      captured++;
    end
    else if (capture_on)
      drops++;
    for (int i = 0; i < CSI_PER_FRAME; i++)
    begin
      step();
      long_preamble_detected = 1'b0;
      sample    = $urandom;
      csi       = sample;
      csi_valid = 1'b1;
      if (i % 2 == 0)
        low_sample = sample;
      else if (take)
        expected.push_back({sample, low_sample});
    end
    step();
    csi_valid = 1'b0;
    repeat (3) step();
  endtask

  task automatic wait_drain();
    while (expected.size() != 0)
      step();
    repeat (2) step();
  endtask

  // random pulses on every event input, counted by the selected sources
  task automatic count_events(input logic [REG_WIDTH-1:0] sel);
    logic [REG_ADDR_WIDTH-1:0] addr;
    int ev_cnt [NUM_EVENTS];
    bit sp;
    bit lp;
    bit hs;
    bit hv;
    bit fs;
    bit fo;
    write_reg(REG_EVENT_SEL, sel);
    for (int i = 0; i < NUM_EVENTS; i++)
    begin
      addr = REG_ADDR_WIDTH'(int'(REG_COUNTER_BASE) + i);
      write_reg(addr, '0);
      check_reg(addr, '0, "counter after clear");
      ev_cnt[i] = 0;
    end
    for (int n = 0; n < 100; n++)
    begin
      step();
      sp = ($urandom_range(2) == 0);
      lp = ($urandom_range(2) == 0);
      hs = ($urandom_range(2) == 0);
      hv = $urandom_range(1);
      fs = ($urandom_range(2) == 0);
      fo = $urandom_range(1);
      short_preamble_detected = sp;
      long_preamble_detected  = lp;
      pkt_header_valid_strobe = hs;
      pkt_header_valid        = hv;
      fcs_in_strobe           = fs;
      fcs_ok                  = fo;
      ev_cnt[0] += sel[0] ? lp : sp;
      ev_cnt[1] += hs && (sel[4] ? !hv : hv);
      ev_cnt[2] += fs && (sel[8] ? !fo : fo);
    end
    step();
    short_preamble_detected = 1'b0;
    long_preamble_detected  = 1'b0;
    pkt_header_valid_strobe = 1'b0;
    fcs_in_strobe           = 1'b0;
    step();
    for (int i = 0; i < NUM_EVENTS; i++)
      check_reg(REG_ADDR_WIDTH'(int'(REG_COUNTER_BASE) + i),
                REG_WIDTH'(COUNTER_WIDTH'(ev_cnt[i])), "event counter");
  endtask

  initial
  begin
    void'($urandom(17236));
    clk                     = 1'b0;
    rst_n                   = 1'b0;
    reg_wr_en               = 1'b0;
    reg_addr                = '0;
    reg_wdata               = '0;
    tsf_runtime_val         = '0;
    long_preamble_detected  = 1'b0;
    short_preamble_detected = 1'b0;
    csi                     = '0;
    csi_valid               = 1'b0;
    pkt_header_valid        = 1'b0;
    pkt_header_valid_strobe = 1'b0;
    fcs_in_strobe           = 1'b0;
    fcs_ok                  = 1'b0;
    m_axis_tready           = 1'b0;
    error_count             = 0;
    cycle_count             = 0;
    beat_cnt                = 0;
    dma_len_model           = 0;
    drops                   = 0;
    captured                = 0;
    capture_on              = 1'b0;
    hold_ready              = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // one frame per transfer
    set_dma_len(FRAME_WORDS);
    set_capture(1'b1);
    repeat (3) send_frame();
    wait_drain();

    // short transfers cut across frame boundaries
    set_dma_len(7);
    repeat (7) send_frame();
    wait_drain();

    // counter 3 has counted captured frames since reset
    check_reg(REG_ADDR_WIDTH'(int'(REG_COUNTER_BASE) + 3), REG_WIDTH'(captured),
              "captured frame counter");

    // counters with capture off so counter 3 stays still
    set_capture(1'b0);
    count_events(32'h0000_0000);
    count_events(32'h0000_1111);

    // stalled stream until the buffer refuses frames
    hold_ready = 1'b1;
    write_reg(REG_EVENT_SEL, 32'h0000_1000);
    write_reg(REG_ADDR_WIDTH'(int'(REG_COUNTER_BASE) + 3), '0);
    set_dma_len(FRAME_WORDS);
    set_capture(1'b1);
    drops = 0;
    for (int f = 0; f < 10; f++)
    begin
      send_frame();
      read_reg(REG_FIFO_COUNT, fill);
      assert (fill <= FIFO_DEPTH && fill == expected.size())
      else
      begin
        error_count++;
        $display("[ERROR] %0t: fill count %0d, expected %0d", $time, fill, expected.size());
      end
    end
    check_reg(REG_ADDR_WIDTH'(int'(REG_COUNTER_BASE) + 3), REG_WIDTH'(drops),
              "dropped frame counter");

    // soft reset empties the buffer and idles the stream
    write_reg(REG_SOFT_RESET, 32'h1);
    write_reg(REG_SOFT_RESET, 32'h0);
    expected.delete();
    beat_cnt = 0;
    check_reg(REG_FIFO_COUNT, '0, "fill count after soft reset");
    hold_ready = 1'b0;
    repeat (20) step();
    send_frame();
    wait_drain();

    repeat (5) step();
    $display("errors: %0d", error_count);
    if (error_count == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* verilog/side_ch.sv */
// side channel top level

`timescale 1ns/1ps

module side_ch
  import side_ch_pkg::*;
#(
  parameter int FIFO_DEPTH    = 256,
  parameter int COUNTER_WIDTH = 16
)
(
  input  logic                      clk,
  input  logic                      rst_n,
  // host registers
  input  logic                      reg_wr_en,
  input  logic [REG_ADDR_WIDTH-1:0] reg_addr,
  input  logic [REG_WIDTH-1:0]      reg_wdata,
  output logic [REG_WIDTH-1:0]      reg_rdata,
  // from receiver
  input  logic [TSF_WIDTH-1:0]      tsf_runtime_val,
  input  logic                      long_preamble_detected,
  input  logic                      short_preamble_detected,
  input  logic [CSI_WIDTH-1:0]      csi,
  input  logic                      csi_valid,
  input  logic                      pkt_header_valid,
  input  logic                      pkt_header_valid_strobe,
  input  logic                      fcs_in_strobe,
  input  logic                      fcs_ok,
  // to host
  output logic                      m_axis_tvalid,
  output logic [AXIS_WIDTH-1:0]     m_axis_tdata,
  output logic                      m_axis_tlast,
  input  logic                      m_axis_tready
);

  logic                 frame_captured;
  logic                 frame_dropped;
  logic [REG_WIDTH-1:0] fifo_count;

  side_ch_cfg_if #(.COUNTER_WIDTH(COUNTER_WIDTH)) cfg_bus ();
  side_ch_fifo_if #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_bus ();

  assign fifo_count = REG_WIDTH'(fifo_bus.count);

  side_ch_regs side_ch_regs_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .reg_wr_en  (reg_wr_en),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .cfg        (cfg_bus.regs),
    .fifo_count (fifo_count)
  );

  side_ch_control #(.FIFO_DEPTH(FIFO_DEPTH)) side_ch_control_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .tsf_runtime_val        (tsf_runtime_val),
    .long_preamble_detected (long_preamble_detected),
    .csi                    (csi),
    .csi_valid              (csi_valid),
    .frame_captured         (frame_captured),
    .frame_dropped          (frame_dropped),
    .cfg                    (cfg_bus.control),
    .fifo                   (fifo_bus.writer)
  );

  side_ch_event_counter #(.COUNTER_WIDTH(COUNTER_WIDTH)) side_ch_event_counter_i (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .short_preamble_detected (short_preamble_detected),
    .long_preamble_detected  (long_preamble_detected),
    .pkt_header_valid_strobe (pkt_header_valid_strobe),
    .pkt_header_valid        (pkt_header_valid),
    .fcs_in_strobe           (fcs_in_strobe),
    .fcs_ok                  (fcs_ok),
    .frame_captured          (frame_captured),
    .frame_dropped           (frame_dropped),
    .cfg                     (cfg_bus.counter)
  );

  side_ch_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) side_ch_fifo_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .soft_reset (cfg_bus.soft_reset),
    .fifo       (fifo_bus.fifo)
  );

  side_ch_m_axis side_ch_m_axis_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg           (cfg_bus.stream),
    .fifo          (fifo_bus.reader),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready)
  );

endmodule

/* verilog/side_ch_cfg_if.sv */
// side channel configuration bus

`timescale 1ns/1ps

interface side_ch_cfg_if
  import side_ch_pkg::*;
#(
  parameter int COUNTER_WIDTH = 16
) ();

  logic                     soft_reset;
  logic                     capture_en;
  logic [REG_WIDTH-1:0]     dma_len;
  logic [NUM_EVENTS-1:0]    event_sel;
  // one-cycle clear per counter
  logic [NUM_EVENTS-1:0]    clear;
  logic [COUNTER_WIDTH-1:0] count0;
  logic [COUNTER_WIDTH-1:0] count1;
  logic [COUNTER_WIDTH-1:0] count2;
  logic [COUNTER_WIDTH-1:0] count3;

  modport regs (
    output soft_reset, capture_en, dma_len, event_sel, clear,
    input  count0, count1, count2, count3
  );

  modport control (input soft_reset, capture_en);

  modport stream (input soft_reset, dma_len);

  modport counter (
    input  event_sel, clear,
    output count0, count1, count2, count3
  );

endinterface

/* verilog/side_ch_control.sv */
// side channel csi capture control

`timescale 1ns/1ps

module side_ch_control
  import side_ch_pkg::*;
#(
  parameter int FIFO_DEPTH = 256
)
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [TSF_WIDTH-1:0] tsf_runtime_val,
  input  logic                 long_preamble_detected,
  input  logic [CSI_WIDTH-1:0] csi,
  input  logic                 csi_valid,
  output logic                 frame_captured,
  output logic                 frame_dropped,
  side_ch_cfg_if.control       cfg,
  side_ch_fifo_if.writer       fifo
);

  localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH) + 1;
  localparam int SAMPLE_WIDTH = $clog2(CSI_PER_FRAME);
  localparam logic [SAMPLE_WIDTH-1:0] LAST_SAMPLE = SAMPLE_WIDTH'(CSI_PER_FRAME - 1);

  logic                    capturing_q;
  logic [SAMPLE_WIDTH-1:0] sample_cnt_q;
  logic                    wr_en_q;
  logic [AXIS_WIDTH-1:0]   wr_data_q;
  logic [CSI_WIDTH-1:0]    csi_low_q;
  logic                    frame_captured_q;
  logic                    frame_dropped_q;
  logic [COUNT_WIDTH-1:0]  used_words;
  logic                    has_room;

  // a word in flight is not yet in the fill count
  assign used_words = fifo.count + COUNT_WIDTH'(wr_en_q);
  assign has_room   = (used_words <= COUNT_WIDTH'(FIFO_DEPTH - FRAME_WORDS));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      capturing_q      <= 1'b0;
      sample_cnt_q     <= '0;
      wr_en_q          <= 1'b0;
      frame_captured_q <= 1'b0;
      frame_dropped_q  <= 1'b0;
    end
    else if (cfg.soft_reset)
    begin
      capturing_q      <= 1'b0;
      sample_cnt_q     <= '0;
      wr_en_q          <= 1'b0;
      frame_captured_q <= 1'b0;
      frame_dropped_q  <= 1'b0;
    end
    else
    begin
      wr_en_q          <= 1'b0;
      frame_captured_q <= 1'b0;
      frame_dropped_q  <= 1'b0;
      if (!capturing_q)
      begin
        if (long_preamble_detected && cfg.capture_en)
        begin
          if (has_room)
          begin
            // time stamp word goes out next cycle
            capturing_q  <= 1'b1;
            wr_en_q      <= 1'b1;
            sample_cnt_q <= '0;
          end
          else
            frame_dropped_q <= 1'b1;
        end
      end
      else if (csi_valid)
      begin
        sample_cnt_q <= sample_cnt_q + 1'b1;
        // odd sample completes a pair
        if (sample_cnt_q[0])
          wr_en_q <= 1'b1;
        if (sample_cnt_q == LAST_SAMPLE)
        begin
          capturing_q      <= 1'b0;
          frame_captured_q <= 1'b1;
        end
      end
    end
  end

  // payload path
  always_ff @(posedge clk)
  begin
    if (!capturing_q)
      wr_data_q <= tsf_runtime_val;
    else if (csi_valid)
    begin
      if (!sample_cnt_q[0])
        csi_low_q <= csi;
      else
        wr_data_q <= {csi, csi_low_q};
    end
  end

  assign fifo.wr_en    = wr_en_q;
  assign fifo.wr_data  = wr_data_q;
  assign frame_captured = frame_captured_q;
  assign frame_dropped  = frame_dropped_q;

endmodule

/* verilog/side_ch_event_counter.sv */
// side channel event counters

`timescale 1ns/1ps

module side_ch_event_counter
  import side_ch_pkg::*;
#(
  parameter int COUNTER_WIDTH = 16
)
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           short_preamble_detected,
  input  logic           long_preamble_detected,
  input  logic           pkt_header_valid_strobe,
  input  logic           pkt_header_valid,
  input  logic           fcs_in_strobe,
  input  logic           fcs_ok,
  input  logic           frame_captured,
  input  logic           frame_dropped,
  side_ch_cfg_if.counter cfg
);

  logic [NUM_EVENTS-1:0]    evt;
  logic [COUNTER_WIDTH-1:0] count_q [NUM_EVENTS];

  // select bit low picks the first source
  assign evt[0] = cfg.event_sel[0] ? long_preamble_detected : short_preamble_detected;
  assign evt[1] = pkt_header_valid_strobe &
                  (cfg.event_sel[1] ? ~pkt_header_valid : pkt_header_valid);
  assign evt[2] = fcs_in_strobe & (cfg.event_sel[2] ? ~fcs_ok : fcs_ok);
  assign evt[3] = cfg.event_sel[3] ? frame_dropped : frame_captured;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_EVENTS; i++)
        count_q[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_EVENTS; i++)
      begin
        // clear wins over a same-cycle event
        if (cfg.clear[i])
          count_q[i] <= '0;
        else if (evt[i])
          count_q[i] <= count_q[i] + 1'b1;
      end
    end
  end

  assign cfg.count0 = count_q[0];
  assign cfg.count1 = count_q[1];
  assign cfg.count2 = count_q[2];
  assign cfg.count3 = count_q[3];

endmodule

/* verilog/side_ch_fifo.sv */
// side channel fall-through buffer

`timescale 1ns/1ps

module side_ch_fifo
  import side_ch_pkg::*;
#(
  parameter int FIFO_DEPTH = 256
)
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        soft_reset,
  side_ch_fifo_if.fifo fifo
);

  localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH);
  localparam int COUNT_WIDTH = ADDR_WIDTH + 1;

  logic [AXIS_WIDTH-1:0]  mem [FIFO_DEPTH];
  logic [ADDR_WIDTH-1:0]  wr_ptr_q;
  logic [ADDR_WIDTH-1:0]  rd_ptr_q;
  logic [COUNT_WIDTH-1:0] count_q;

  always_ff @(posedge clk)
  begin
    if (fifo.wr_en)
      mem[wr_ptr_q] <= fifo.wr_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else if (soft_reset)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (fifo.wr_en)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (fifo.rd_en)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({fifo.wr_en, fifo.rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // head word is visible without a read
  assign fifo.rd_data = mem[rd_ptr_q];
  assign fifo.empty_n = (count_q != '0);
  assign fifo.count   = count_q;

endmodule

/* verilog/side_ch_fifo_if.sv */
// side channel buffer bus

`timescale 1ns/1ps

interface side_ch_fifo_if
  import side_ch_pkg::*;
#(
  parameter int FIFO_DEPTH = 256
) ();

  // fill count reaches FIFO_DEPTH, so one extra bit
  localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH) + 1;

  logic                   wr_en;
  logic [AXIS_WIDTH-1:0]  wr_data;
  logic                   rd_en;
  logic [AXIS_WIDTH-1:0]  rd_data;
  logic                   empty_n;
  logic [COUNT_WIDTH-1:0] count;

  modport writer (output wr_en, wr_data, input count);

  modport reader (output rd_en, input rd_data, empty_n, count);

  modport fifo (
    input  wr_en, wr_data, rd_en,
    output rd_data, empty_n, count
  );

endinterface

/* verilog/side_ch_m_axis.sv */
// side channel output stream master

`timescale 1ns/1ps

module side_ch_m_axis
  import side_ch_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  side_ch_cfg_if.stream         cfg,
  side_ch_fifo_if.reader        fifo,
  output logic                  m_axis_tvalid,
  output logic [AXIS_WIDTH-1:0] m_axis_tdata,
  output logic                  m_axis_tlast,
  input  logic                  m_axis_tready
);

  logic                 busy_q;
  logic [REG_WIDTH-1:0] len_q;
  logic [REG_WIDTH-1:0] word_cnt_q;
  logic                 start;
  logic                 handshake;
  logic                 last_word;

  // a transfer only starts once all its words are buffered
  assign start     = !busy_q && (cfg.dma_len != '0) &&
                     (REG_WIDTH'(fifo.count) >= cfg.dma_len);
  assign last_word = (word_cnt_q == len_q - 1'b1);
  assign handshake = m_axis_tvalid && m_axis_tready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q     <= 1'b0;
      len_q      <= '0;
      word_cnt_q <= '0;
    end
    else if (cfg.soft_reset)
    begin
      busy_q     <= 1'b0;
      len_q      <= '0;
      word_cnt_q <= '0;
    end
    else if (start)
    begin
      // length held for the whole transfer
      busy_q     <= 1'b1;
      len_q      <= cfg.dma_len;
      word_cnt_q <= '0;
    end
    else if (handshake)
    begin
      if (last_word)
        busy_q <= 1'b0;
      else
        word_cnt_q <= word_cnt_q + 1'b1;
    end
  end

  assign m_axis_tvalid = busy_q && fifo.empty_n;
  assign m_axis_tdata  = fifo.rd_data;
  assign m_axis_tlast  = busy_q && last_word;
  assign fifo.rd_en    = handshake;

endmodule

/* verilog/side_ch_pkg.sv */
// side channel shared constants

package side_ch_pkg;

  // data path widths
  localparam int TSF_WIDTH  = 64;
  localparam int IQ_WIDTH   = 16;
  localparam int CSI_WIDTH  = 2 * IQ_WIDTH;
  localparam int AXIS_WIDTH = 64;

  // host register port
  localparam int REG_WIDTH      = 32;
  localparam int REG_ADDR_WIDTH = 5;

  // one frame is a time stamp word then two csi samples per word
  localparam int CSI_PER_FRAME = 64;
  localparam int FRAME_WORDS   = 1 + CSI_PER_FRAME / 2;

  localparam int NUM_EVENTS = 4;

  // register map
  localparam logic [REG_ADDR_WIDTH-1:0] REG_SOFT_RESET   = REG_ADDR_WIDTH'(0);
  localparam logic [REG_ADDR_WIDTH-1:0] REG_CAPTURE      = REG_ADDR_WIDTH'(1);
  localparam logic [REG_ADDR_WIDTH-1:0] REG_DMA_LEN      = REG_ADDR_WIDTH'(2);
  localparam logic [REG_ADDR_WIDTH-1:0] REG_EVENT_SEL    = REG_ADDR_WIDTH'(19);
  localparam logic [REG_ADDR_WIDTH-1:0] REG_FIFO_COUNT   = REG_ADDR_WIDTH'(20);
  // counters sit at base .. base+3
  localparam logic [REG_ADDR_WIDTH-1:0] REG_COUNTER_BASE = REG_ADDR_WIDTH'(26);

endpackage

/* verilog/side_ch_regs.sv */
// side channel host registers

`timescale 1ns/1ps

module side_ch_regs
  import side_ch_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      reg_wr_en,
  input  logic [REG_ADDR_WIDTH-1:0] reg_addr,
  input  logic [REG_WIDTH-1:0]      reg_wdata,
  output logic [REG_WIDTH-1:0]      reg_rdata,
  side_ch_cfg_if.regs               cfg,
  input  logic [REG_WIDTH-1:0]      fifo_count
);

  logic                  soft_reset_q;
  logic                  capture_q;
  logic [REG_WIDTH-1:0]  dma_len_q;
  logic [NUM_EVENTS-1:0] event_sel_q;
  logic [NUM_EVENTS-1:0] clear_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      soft_reset_q <= 1'b0;
      capture_q    <= 1'b0;
      dma_len_q    <= '0;
      event_sel_q  <= '0;
      clear_q      <= '0;
    end
    else
    begin
      clear_q <= '0;
      if (reg_wr_en)
      begin
        case (reg_addr)
          REG_SOFT_RESET: soft_reset_q <= reg_wdata[0];
          REG_CAPTURE:    capture_q    <= reg_wdata[0];
          REG_DMA_LEN:    dma_len_q    <= reg_wdata;
          REG_EVENT_SEL:
          begin
            // select bits are spaced one nibble apart
            for (int i = 0; i < NUM_EVENTS; i++)
              event_sel_q[i] <= reg_wdata[4*i];
          end
          default: ;
        endcase
        // any write to a counter address clears it, data ignored
        for (int i = 0; i < NUM_EVENTS; i++)
          if (reg_addr == REG_ADDR_WIDTH'(REG_COUNTER_BASE + i))
            clear_q[i] <= 1'b1;
      end
    end
  end

  assign cfg.soft_reset = soft_reset_q;
  assign cfg.capture_en = capture_q;
  assign cfg.dma_len    = dma_len_q;
  assign cfg.event_sel  = event_sel_q;
  assign cfg.clear      = clear_q;

  // readback
  always_comb
  begin
    reg_rdata = '0;
    case (reg_addr)
      REG_SOFT_RESET: reg_rdata[0] = soft_reset_q;
      REG_CAPTURE:    reg_rdata[0] = capture_q;
      REG_DMA_LEN:    reg_rdata    = dma_len_q;
      REG_EVENT_SEL:
      begin
        for (int i = 0; i < NUM_EVENTS; i++)
          reg_rdata[4*i] = event_sel_q[i];
      end
      REG_FIFO_COUNT:           reg_rdata = fifo_count;
      REG_COUNTER_BASE:         reg_rdata = REG_WIDTH'(cfg.count0);
      REG_COUNTER_BASE + 5'd1:  reg_rdata = REG_WIDTH'(cfg.count1);
      REG_COUNTER_BASE + 5'd2:  reg_rdata = REG_WIDTH'(cfg.count2);
      REG_COUNTER_BASE + 5'd3:  reg_rdata = REG_WIDTH'(cfg.count3);
      default: ;
    endcase
  end

endmodule
